// File: verilog.f
+incdir+.
mem_pkg.sv
mem_port_if.sv
mem_port_ctrl.sv
mem_rr_arbiter.sv
mem_data_path.sv
dual_port_test_mem.sv
tb_dual_port_test_mem.sv

// File: Makefile
# Verilator build and run of the dual-port test memory testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       = tb_dual_port_test_mem
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fails unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_mem_model.svh
// reference model of the test memory
// one byte per address, expected response computed when a request is accepted

`ifndef tb_mem_model_svh
`define tb_mem_model_svh

logic [7:0] model_bytes [c_mem_sz];

// address wraps at the memory size
function automatic int byte_index(input addr_t addr);
  return int'(addr) % c_mem_sz;
endfunction

// little-endian word holding the address
function automatic data_t model_word(input addr_t addr);
  int    base;
  int    i;
  data_t w;
  base = byte_index(addr) & ~3;
  for (i = 0; i < 4; i++)
    w[8*i +: 8] = model_bytes[base + i];
  return w;
endfunction

function automatic void store_word(input addr_t addr, input data_t w);
  int base;
  int i;
  base = byte_index(addr) & ~3;
  for (i = 0; i < 4; i++)
    model_bytes[base + i] = w[8*i +: 8];
endfunction

// expected response, model state updated on the way
function automatic mem_resp_t model_access(input mem_req_t req);
  mem_resp_t resp;
  data_t     old_w;
  int        idx;
  int        nbytes;
  int        i;
  old_w     = model_word(req.addr);
  idx       = byte_index(req.addr);
  resp.op   = req.op;
  resp.len  = req.len;
  resp.data = '0;
  case (req.len)
    len_byte: nbytes = 1;
    len_half: nbytes = 2;
    default:  nbytes = 4;
  endcase
  if (req.len == len_word)
    idx = idx & ~3;  // words start at the word boundary
  case (req.op)
    mem_rd:
      for (i = 0; i < nbytes; i++)
        resp.data[8*i +: 8] = model_bytes[idx + i];
    mem_wr:
      for (i = 0; i < nbytes; i++)
        model_bytes[idx + i] = req.data[8*i +: 8];
    mem_amo_add:
    begin
      resp.data = old_w;
      store_word(req.addr, old_w + req.data);
    end
    mem_amo_and:
    begin
      resp.data = old_w;
      store_word(req.addr, old_w & req.data);
    end
    mem_amo_or:
    begin
      resp.data = old_w;
      store_word(req.addr, old_w | req.data);
    end
    default: resp.data = '0;
  endcase
  return resp;
endfunction

`endif

// File: tb_dual_port_test_mem.sv
// testbench of the dual-port test memory
// directed and random traffic on both ports against a byte model

`timescale 1ns/1ns

module tb_dual_port_test_mem
  import mem_pkg::*;
();

  localparam int c_mem_sz  = 1024;
  localparam int c_half    = c_mem_sz / 2;  // bytes per port region
  localparam int c_n_rand  = 200;
  localparam int c_timeout = 2000;          // cycles

  logic      clk;
  logic      rst_n;
  logic      req0_val;
  logic      req0_rdy;
  mem_req_t  req0;
  logic      resp0_val;
  logic      resp0_rdy;
  mem_resp_t resp0;
  logic      req1_val;
  logic      req1_rdy;
  mem_req_t  req1;
  logic      resp1_val;
  logic      resp1_rdy;
  mem_resp_t resp1;

  mem_resp_t exp_q0 [$];
  mem_resp_t exp_q1 [$];
  mem_req_t  rand_reqs [2][c_n_rand];
  mem_resp_t held;
  data_t     last_data [2];  // data of the last response taken per port
  integer    seed;
  string     test_name;
  int        n_tests;
  int        n_checks;
  int        n_errors;
  int        test_errors;
  int        i;
  logic      traffic_on;

  `include "tb_mem_model.svh"

  dual_port_test_mem #(
    .p_mem_sz (c_mem_sz)
  ) i_dual_port_test_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .req0_val  (req0_val),
    .req0_rdy  (req0_rdy),
    .req0      (req0),
    .resp0_val (resp0_val),
    .resp0_rdy (resp0_rdy),
    .resp0     (resp0),
    .req1_val  (req1_val),
    .req1_rdy  (req1_rdy),
    .req1      (req1),
    .resp1_val (resp1_val),
    .resp1_rdy (resp1_rdy),
    .resp1     (resp1)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------
  // checks and bookkeeping
  // ----------------------------------------

  task automatic compare(input string name, input logic [63:0] exp_val,
                         input logic [63:0] act_val);
    n_checks++;
    if (act_val !== exp_val)
    begin
      n_errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = n_errors;
  endtask

  task automatic end_test();
    n_tests++;
    $display("test %-8s %s", test_name, (n_errors == test_errors) ? "ok" : "failed");
  endtask

  // responses sampled at the falling edge
  task automatic take_resp(input int p, input mem_resp_t act);
    mem_resp_t exp_resp;
    if ((p == 0 && exp_q0.size() == 0) || (p == 1 && exp_q1.size() == 0))
    begin
      n_errors++;
      $display("port %0d returned a response with none outstanding", p);
    end
    else
    begin
      if (p == 0)
        exp_resp = exp_q0.pop_front();
      else
        exp_resp = exp_q1.pop_front();
      last_data[p] = act.data;
      compare($sformatf("%s port %0d resp", test_name, p), 64'(exp_resp), 64'(act));
    end
  endtask

  always @(negedge clk)
  begin
    if (rst_n && resp0_val && resp0_rdy)
      take_resp(0, resp0);
    if (rst_n && resp1_val && resp1_rdy)
      take_resp(1, resp1);
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  function automatic data_t fill_word(input addr_t a);
    return {a, ~a};
  endfunction

  function automatic mem_req_t make_req(input mem_op_e op, input int addr,
                                        input mem_len_e len, input data_t data);
    mem_req_t r;
    r.op   = op;
    r.addr = addr_t'(addr);
    r.len  = len;
    r.data = data;
    return r;
  endfunction

  task automatic drive_port(input int p, input logic val, input mem_req_t r);
    if (p == 0)
    begin
      req0_val = val;
      req0     = r;
    end
    else
    begin
      req1_val = val;
      req1     = r;
    end
  endtask

  // hold the request until accepted, then predict its response
  task automatic send_req(input int p, input mem_req_t r);
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    drive_port(p, 1'b1, r);
    while (!taken && waited < c_timeout)
    begin
      @(negedge clk);
      taken = (p == 0) ? req0_rdy : req1_rdy;
      waited++;
      @(posedge clk);
      #1;
    end
    drive_port(p, 1'b0, r);
    if (!taken)
    begin
      n_errors++;
      $display("port %0d request was not accepted within %0d cycles", p, c_timeout);
    end
    else if (p == 0)
      exp_q0.push_back(model_access(r));
    else
      exp_q1.push_back(model_access(r));
  endtask

  task automatic sweep_region(input int p, input mem_op_e op);
    int   k;
    int   a;
    for (k = 0; k < c_half / 4; k++)
    begin
      a = p * c_half + 4 * k;
      send_req(p, make_req(op, a, len_word, fill_word(addr_t'(a))));
    end
  endtask

  task automatic build_random_reqs();
    int       p;
    int       k;
    int       off;
    mem_req_t r;
    for (p = 0; p < 2; p++)
      for (k = 0; k < c_n_rand; k++)
      begin
        r.op = mem_op_e'(3'({$random(seed)} % 5));
        if (r.op inside {mem_amo_add, mem_amo_and, mem_amo_or})
          r.len = len_word;
        else
          r.len = mem_len_e'(2'({$random(seed)} % 3));
        off = {$random(seed)} % c_half;
        if (r.len == len_word)
          off = off & ~3;
        else if (r.len == len_half)
          off = off & ~1;
        r.addr = addr_t'(p * c_half + off);  // each port stays in its half
        r.data = $random(seed);
        rand_reqs[p][k] = r;
      end
  endtask

  task automatic run_random(input int p);
    int k;
    for (k = 0; k < c_n_rand; k++)
      send_req(p, rand_reqs[p][k]);
  endtask

  task automatic toggle_stalls();
    int cycles;
    cycles = 0;
    while (traffic_on && cycles < 20 * c_n_rand)
    begin
      @(posedge clk);
      #1;
      resp0_rdy = ({$random(seed)} % 4) != 0;  // ready 3 of 4 cycles
      resp1_rdy = ({$random(seed)} % 4) != 0;
      cycles++;
    end
    resp0_rdy = 1'b1;
    resp1_rdy = 1'b1;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while ((exp_q0.size() != 0 || exp_q1.size() != 0) && waited < c_timeout)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_q0.size() != 0 || exp_q1.size() != 0)
    begin
      n_errors++;
      $display("responses still outstanding after %0d cycles", c_timeout);
    end
  endtask

  // port 0 stalled with a full response and a held request
  task automatic wait_stalled(output mem_resp_t snap);
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    snap   = '0;
    while (!done && waited < c_timeout)
    begin
      @(negedge clk);
      done = resp0_val && !req0_rdy;
      snap = resp0;
      waited++;
      @(posedge clk);
      #1;
    end
    if (!done)
    begin
      n_errors++;
      $display("port 0 never stalled with a held request and response");
    end
  endtask

  task automatic watch_stall(input mem_resp_t snap);
    int waited;
    waited = 0;
    while ((traffic_on || exp_q1.size() != 0) && waited < c_timeout)
    begin
      @(negedge clk);
      compare("stall resp0", 64'(snap), 64'(resp0));
      compare("stall resp0_val", 64'(1), 64'(resp0_val));
      compare("stall req0_rdy", 64'(0), 64'(req0_rdy));
      waited++;
      @(posedge clk);
      #1;
    end
    if (exp_q1.size() != 0)
    begin
      n_errors++;
      $display("port 1 did not complete its requests while port 0 was stalled");
    end
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------

  initial
  begin
    seed        = 32'h3b26;
    n_tests     = 0;
    n_checks    = 0;
    n_errors    = 0;
    test_errors = 0;
    test_name   = "";
    traffic_on  = 1'b0;
    rst_n       = 1'b0;
    req0_val    = 1'b0;
    req0        = '0;
    resp0_rdy   = 1'b1;
    req1_val    = 1'b0;
    req1        = '0;
    resp1_rdy   = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    begin_test("reset");
    @(negedge clk);
    compare("reset req0_rdy", 64'(1), 64'(req0_rdy));
    compare("reset req1_rdy", 64'(1), 64'(req1_rdy));
    compare("reset resp0_val", 64'(0), 64'(resp0_val));
    compare("reset resp1_val", 64'(0), 64'(resp1_val));
    @(posedge clk);
    #1;
    end_test();

    begin_test("word");
    fork
      sweep_region(0, mem_wr);
      sweep_region(1, mem_wr);
    join
    fork
      sweep_region(0, mem_rd);
      sweep_region(1, mem_rd);
    join
    wait_idle();
    end_test();

    begin_test("subword");
    send_req(0, make_req(mem_wr, 'h40, len_word, 32'h1122_3344));
    send_req(0, make_req(mem_wr, 'h41, len_byte, 32'h5566_77ab));  // low byte only
    send_req(0, make_req(mem_rd, 'h40, len_word, '0));  // upper lanes untouched by the byte
    send_req(0, make_req(mem_wr, 'h42, len_half, 32'h9988_beef));
    send_req(0, make_req(mem_rd, 'h41, len_byte, '0));
    send_req(0, make_req(mem_rd, 'h42, len_half, '0));
    send_req(0, make_req(mem_rd, 'h43, len_byte, '0));
    send_req(0, make_req(mem_rd, 'h40, len_word, '0));
    wait_idle();
    compare("subword word", 64'(32'hbeef_ab44), 64'(last_data[0]));
    end_test();

    begin_test("atomic");
    send_req(1, make_req(mem_wr, 'h280, len_word, 32'h1234_5678));
    send_req(1, make_req(mem_amo_add, 'h280, len_word, 32'h8765_4321));
    send_req(1, make_req(mem_amo_and, 'h280, len_word, 32'hff00_ff00));
    send_req(1, make_req(mem_amo_or, 'h280, len_word, 32'h00be_00ef));
    send_req(1, make_req(mem_rd, 'h280, len_word, '0));
    wait_idle();
    compare("atomic word", 64'(32'h99be_99ef), 64'(last_data[1]));
    end_test();

    begin_test("random");
    build_random_reqs();
    traffic_on = 1'b1;
    fork
      begin
        fork
          run_random(0);
          run_random(1);
        join
        traffic_on = 1'b0;
      end
      toggle_stalls();
    join
    wait_idle();
    end_test();

    begin_test("stall");
    resp0_rdy = 1'b0;
    send_req(0, make_req(mem_rd, 'h10, len_word, '0));
    send_req(0, make_req(mem_rd, 'h14, len_word, '0));
    wait_stalled(held);
    traffic_on = 1'b1;
    fork
      begin
        for (i = 0; i < 8; i++)
          send_req(1, make_req(mem_rd, c_half + 4 * i, len_word, '0));
        traffic_on = 1'b0;
      end
      watch_stall(held);
    join
    compare("stall pending", 64'(2), 64'(exp_q0.size()));
    resp0_rdy = 1'b1;  // both held responses follow the release
    wait_idle();
    end_test();

    $display("tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// File: dual_port_test_mem.sv
// dual-port test memory top level
// two val/rdy ports share one storage array by round-robin

`timescale 1ns/1ns

module dual_port_test_mem
  import mem_pkg::*;
#(
  parameter int p_mem_sz = 1024
)(
  input  logic      clk,
  input  logic      rst_n,
  // port 0
  input  logic      req0_val,
  output logic      req0_rdy,
  input  mem_req_t  req0,
  output logic      resp0_val,
  input  logic      resp0_rdy,
  output mem_resp_t resp0,
  // port 1
  input  logic      req1_val,
  output logic      req1_rdy,
  input  mem_req_t  req1,
  output logic      resp1_val,
  input  logic      resp1_rdy,
  output mem_resp_t resp1
);

  mem_port_if port0_if ();
  mem_port_if port1_if ();

  logic [1:0] want;
  logic [1:0] grant;
  mem_req_t   held_req0;
  mem_req_t   held_req1;
  mem_req_t   sel_req;
  logic       sel_val;
  data_t      result;

  // ----------------------------------------
  // plain ports onto the port bundles
  // ----------------------------------------

  assign port0_if.req_val  = req0_val;
  assign port0_if.req      = req0;
  assign port0_if.resp_rdy = resp0_rdy;
  assign req0_rdy          = port0_if.req_rdy;
  assign resp0_val         = port0_if.resp_val;
  assign resp0             = port0_if.resp;

  assign port1_if.req_val  = req1_val;
  assign port1_if.req      = req1;
  assign port1_if.resp_rdy = resp1_rdy;
  assign req1_rdy          = port1_if.req_rdy;
  assign resp1_val         = port1_if.resp_val;
  assign resp1             = port1_if.resp;

  // ----------------------------------------
  // blocks
  // ----------------------------------------

  mem_port_ctrl i_port0_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .port     (port0_if.ctrl),
    .want     (want[0]),
    .held_req (held_req0),
    .grant    (grant[0]),
    .result   (result)
  );

  mem_port_ctrl i_port1_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .port     (port1_if.ctrl),
    .want     (want[1]),
    .held_req (held_req1),
    .grant    (grant[1]),
    .result   (result)
  );

  mem_rr_arbiter i_arbiter (
    .clk     (clk),
    .rst_n   (rst_n),
    .want    (want),
    .req_in0 (held_req0),
    .req_in1 (held_req1),
    .grant   (grant),
    .sel_req (sel_req),
    .sel_val (sel_val)
  );

  mem_data_path #(
    .p_mem_sz (p_mem_sz)
  ) i_data_path (
    .clk     (clk),
    .sel_val (sel_val),
    .sel_req (sel_req),
    .result  (result)
  );

endmodule

// File: mem_data_path.sv
// storage array and data path of the test memory
// subword read and insert by lane, atomic add, and, or on words

`timescale 1ns/1ns

module mem_data_path
  import mem_pkg::*;
#(
  parameter int p_mem_sz = 1024  // bytes, power of two
)(
  input  logic     clk,
  input  logic     sel_val,
  input  mem_req_t sel_req,
  output data_t    result
);

  localparam int c_words  = p_mem_sz / 4;
  localparam int c_idx_sz = $clog2(c_words);

  data_t mem [c_words];

  logic [c_idx_sz-1:0] word_idx;
  logic [4:0]          shift;
  data_t               old_word;
  data_t               lane_mask;
  data_t               rd_data;
  data_t               ins_word;
  data_t               new_word;
  logic                wr_en;

  // address modulo memory size
  assign word_idx = sel_req.addr[c_idx_sz+1:2];
  assign old_word = mem[word_idx];

  // ----------------------------------------
  // lane select and insert
  // ----------------------------------------

  always_comb
  begin
    case (sel_req.len)
      len_byte: lane_mask = 32'h0000_00ff;
      len_half: lane_mask = 32'h0000_ffff;
      default:  lane_mask = 32'hffff_ffff;
    endcase
    // words ignore the low address bits
    shift    = (sel_req.len == len_word) ? 5'd0 : {sel_req.addr[1:0], 3'b000};
    rd_data  = (old_word >> shift) & lane_mask;  // zero-extended
    ins_word = (old_word & ~(lane_mask << shift))
             | ((sel_req.data & lane_mask) << shift);
  end

  // ----------------------------------------
  // op decode
  // ----------------------------------------

  always_comb
  begin
    result   = '0;
    new_word = old_word;
    wr_en    = 1'b0;
    case (sel_req.op)
      mem_rd:      result = rd_data;
      mem_wr:
      begin
        new_word = ins_word;  // response data stays zero
        wr_en    = 1'b1;
      end
      mem_amo_add:
      begin
        result   = old_word;
        new_word = old_word + sel_req.data;
        wr_en    = 1'b1;
      end
      mem_amo_and:
      begin
        result   = old_word;
        new_word = old_word & sel_req.data;
        wr_en    = 1'b1;
      end
      mem_amo_or:
      begin
        result   = old_word;
        new_word = old_word | sel_req.data;
        wr_en    = 1'b1;
      end
      default:     result = '0;
    endcase
  end

  // store at the end of the grant cycle
  always_ff @(posedge clk)
  begin
    if (sel_val && wr_en)
      mem[word_idx] <= new_word;
  end

  a_amo_word : assert property (@(posedge clk)
    sel_val && (sel_req.op inside {mem_amo_add, mem_amo_and, mem_amo_or})
    |-> sel_req.len == len_word);

  a_half_even : assert property (@(posedge clk)
    sel_val && sel_req.len == len_half |-> !sel_req.addr[0]);

endmodule

// File: mem_rr_arbiter.sv
// round-robin arbiter for two memory ports
// grants one requester per cycle and forwards its request

`timescale 1ns/1ns

module mem_rr_arbiter
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic [1:0] want,
  input  mem_req_t   req_in0,
  input  mem_req_t   req_in1,
  output logic [1:0] grant,
  output mem_req_t   sel_req,
  output logic       sel_val
);

  logic last_q;  // port served last, loses the next tie

  always_comb
  begin
    if (want == 2'b11)
      grant = last_q ? 2'b01 : 2'b10;
    else
      grant = want;
  end

  assign sel_val = |grant;
  assign sel_req = grant[1] ? req_in1 : req_in0;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      last_q <= 1'b1;  // port 0 wins the first tie
    else if (sel_val)
      last_q <= grant[1];
  end

  a_grant_legal : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant) && ((grant & ~want) == 2'b00));

endmodule

// File: mem_port_ctrl.sv
// memory port controller
// one request register and one response register per port

`timescale 1ns/1ns

module mem_port_ctrl
  import mem_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  mem_port_if.ctrl port,
  output logic     want,
  output mem_req_t held_req,
  input  logic     grant,
  input  data_t    result
);

  logic      req_full;
  mem_req_t  req_q;
  logic      resp_val_q;
  mem_resp_t resp_q;
  logic      resp_free;

  // ----------------------------------------
  // request side
  // ----------------------------------------

  // a new request may enter while the held one is granted
  assign port.req_rdy = !req_full || grant;
  assign held_req     = req_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      req_full <= 1'b0;
    else if (port.req_val && port.req_rdy)
      req_full <= 1'b1;
    else if (grant)
      req_full <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (port.req_val && port.req_rdy)
      req_q <= port.req;  // payload only
  end

  // ----------------------------------------
  // response side
  // ----------------------------------------

  assign resp_free = !resp_val_q || port.resp_rdy;  // empty or draining now
  assign want      = req_full && resp_free;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      resp_val_q <= 1'b0;
    else if (grant)
      resp_val_q <= 1'b1;
    else if (port.resp_rdy)
      resp_val_q <= 1'b0;
  end

  // result arrives already lane aligned
  always_ff @(posedge clk)
  begin
    if (grant)
    begin
      resp_q.op   <= req_q.op;
      resp_q.len  <= req_q.len;
      resp_q.data <= result;
    end
  end

  assign port.resp_val = resp_val_q;
  assign port.resp     = resp_q;

  // held response must not change under back-pressure
  a_resp_hold : assert property (@(posedge clk) disable iff (!rst_n)
    port.resp_val && !port.resp_rdy |=> port.resp_val && $stable(port.resp));

  a_len_legal : assert property (@(posedge clk) disable iff (!rst_n)
    req_full |-> 2'(req_q.len) != 2'd3);

endmodule

// File: mem_port_if.sv
// request and response bundle of one memory port
// val/rdy handshake on both directions

`timescale 1ns/1ns

interface mem_port_if
  import mem_pkg::*;
();

  // request channel
  logic      req_val;
  logic      req_rdy;
  mem_req_t  req;

  // response channel
  logic      resp_val;
  logic      resp_rdy;
  mem_resp_t resp;

  // memory side of the port
  modport ctrl (
    input  req_val, req, resp_rdy,
    output req_rdy, resp_val, resp
  );

  // requester side
  modport host (
    output req_val, req, resp_rdy,
    input  req_rdy, resp_val, resp
  );

endinterface

// File: mem_pkg.sv
// memory message package
// widths, op and length encodings, request and response structs

package mem_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  localparam int c_addr_sz = 16;  // byte address
  localparam int c_data_sz = 32;  // one word

  typedef logic [c_addr_sz-1:0] addr_t;
  typedef logic [c_data_sz-1:0] data_t;

  // ----------------------------------------
  // encodings
  // ----------------------------------------

  typedef enum logic [2:0] {
    mem_rd,
    mem_wr,
    mem_amo_add,
    mem_amo_and,
    mem_amo_or
  } mem_op_e;

  // 3 is illegal
  typedef enum logic [1:0] {
    len_word = 2'd0,
    len_byte = 2'd1,
    len_half = 2'd2
  } mem_len_e;

  // ----------------------------------------
  // messages
  // ----------------------------------------

  typedef struct packed {
    mem_op_e  op;
    addr_t    addr;
    mem_len_e len;
    data_t    data;   // write data or atomic operand
  } mem_req_t;

  typedef struct packed {
    mem_op_e  op;
    mem_len_e len;
    data_t    data;   // read data, zero for writes
  } mem_resp_t;

endpackage
